//--- source/xadc_macros.svh
`ifndef XADC_MACROS_SVH
`define XADC_MACROS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

`define XADC_RESULT_W      12   // One ADC conversion
`define XADC_WORD_W        64   // Event FIFO word
`define XADC_SLOTS         5    // Results per FIFO word

//////////////////////////////////////////////////
// Framing and flow control
//////////////////////////////////////////////////

`define XADC_MAX_WORDS     150  // Words per UDP frame
`define XADC_FIFO_CREDITS  4    // Initial credits from the FIFO side
`define XADC_LEN_W         12   // Packet length field

// Run command fields
`define XADC_CHANNELS      8
`define XADC_COUNT_W       11   // Samples per channel
`define XADC_DELAY_W       18   // Inter-sample delay in clk125 cycles

`endif

//--- source/xadc_ctrl_pkg.sv
`include "xadc_macros.svh"

package xadc_ctrl_pkg;

    //////////////////////////////////////////////////
    // Run command
    //////////////////////////////////////////////////

    // Chip ids above 7 request a sweep over all channels
    typedef struct packed
    {
        logic [3:0]                     chip_id;
        logic [`XADC_COUNT_W-1:0]       sample_count;   // Conversions per channel
        logic [`XADC_DELAY_W-1:0]       delay_cycles;   // Wait between conversions
    } run_cmd_t;

    //////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        SEQ_IDLE,           // Waiting for cmd_rdy
        SEQ_CONVERT,        // Request a conversion once the packer has room
        SEQ_WAIT_RESULT,    // Conversion in flight
        SEQ_DELAY,          // Inter-sample delay
        SEQ_FLUSH,          // Last word draining to the FIFO
        SEQ_WAIT_UDP        // Frame handed off, wait for the network side
    } seq_state_e;

endpackage

//--- source/xadc_data_pkg.sv
`include "xadc_macros.svh"

package xadc_data_pkg;

    // One conversion on its way to the packer
    typedef struct packed
    {
        logic [`XADC_RESULT_W-1:0]      result;
        logic [2:0]                     chan;
        logic                           last;       // Final sample of this channel
    } sample_t;

    //////////////////////////////////////////////////
    // Event FIFO word
    //////////////////////////////////////////////////

    // Packer fills valid and data only, the writer adds the framing
    typedef struct packed
    {
        logic                           valid;
        logic [`XADC_WORD_W-1:0]        data;
        logic [`XADC_LEN_W-1:0]         packet_len; // 1-based index in the frame
        logic                           end_of_data;
    } fifo_word_t;

    // Frame writer states
    typedef enum logic [1:0]
    {
        WR_IDLE,
        WR_EMIT,    // fifo_out valid for this one cycle
        WR_SETTLE
    } wr_state_e;

endpackage

//--- source/sample_sequencer.sv
`timescale 1ns/1ps
`include "xadc_macros.svh"

module sample_sequencer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        cmd_rdy,
    input  xadc_ctrl_pkg::run_cmd_t     cmd,
    output logic                        conv_start,
    output logic [2:0]                  conv_chan,
    input  logic                        conv_done,
    input  logic [`XADC_RESULT_W-1:0]   conv_result,
    input  logic                        pack_ready,
    output xadc_data_pkg::sample_t      sample,
    output logic                        sample_push,
    output logic                        timer_start,
    output logic                        delay_start,
    input  logic                        last_sample,
    input  logic                        delay_done,
    input  logic                        writer_idle,
    input  logic                        udp_done,
    output logic                        busy
);
    import xadc_ctrl_pkg::*;

    seq_state_e state;
    logic [2:0] chan;
    logic       all_chan;   // Sweep mode
    logic       more_chan;

    assign conv_chan = chan;
    assign more_chan = all_chan && (chan != 3'(`XADC_CHANNELS - 1));

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state       <= SEQ_IDLE;
            busy        <= 1'b0;
            chan        <= 3'd0;
            all_chan    <= 1'b0;
            conv_start  <= 1'b0;
            sample_push <= 1'b0;
            timer_start <= 1'b0;
            delay_start <= 1'b0;
        end
        else
        begin
            // Pulses by default
            conv_start  <= 1'b0;
            sample_push <= 1'b0;
            timer_start <= 1'b0;
            delay_start <= 1'b0;

            case (state)
                SEQ_IDLE:
                begin
                    if (cmd_rdy && !busy)
                    begin
                        busy        <= 1'b1;
                        all_chan    <= (cmd.chip_id >= 4'(`XADC_CHANNELS));
                        chan        <= (cmd.chip_id >= 4'(`XADC_CHANNELS)) ? 3'd0 : cmd.chip_id[2:0];
                        timer_start <= 1'b1;
                        state       <= SEQ_CONVERT;
                    end
                end

                SEQ_CONVERT:
                begin
                    // A push still in flight has not reached pack_ready yet
                    if (pack_ready && !sample_push)
                    begin
                        conv_start <= 1'b1;
                        state      <= SEQ_WAIT_RESULT;
                    end
                end

                SEQ_WAIT_RESULT:
                begin
                    if (conv_done)
                    begin
                        sample_push <= 1'b1;
                        if (!last_sample)
                        begin
                            delay_start <= 1'b1;
                            state       <= SEQ_DELAY;
                        end
                        else if (more_chan)
                        begin
                            chan        <= chan + 3'd1; // Next chip, no delay
                            timer_start <= 1'b1;
                            state       <= SEQ_CONVERT;
                        end
                        else
                            state <= SEQ_FLUSH;
                    end
                end

                SEQ_DELAY:
                    if (delay_done)
                        state <= SEQ_CONVERT;

                SEQ_FLUSH:
                    if (!sample_push && pack_ready && writer_idle)
                        state <= SEQ_WAIT_UDP;

                SEQ_WAIT_UDP:
                begin
                    // Old command must drop before a new run
                    if (!cmd_rdy && udp_done)
                    begin
                        busy  <= 1'b0;
                        state <= SEQ_IDLE;
                    end
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Tag the result with its channel
    always_ff @(posedge clk125)
    begin
        if (state == SEQ_WAIT_RESULT && conv_done)
            sample <= '{result: conv_result, chan: chan, last: last_sample};
    end

endmodule

//--- source/sample_timer.sv
`timescale 1ns/1ps
`include "xadc_macros.svh"

module sample_timer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        timer_start,
    input  logic                        sample_tick,
    input  logic                        delay_start,
    input  logic [`XADC_COUNT_W-1:0]    sample_count,
    input  logic [`XADC_DELAY_W-1:0]    delay_cycles,
    output logic                        last_sample,
    output logic                        delay_done
);
    logic [`XADC_COUNT_W-1:0] remaining;    // Pushes left in this channel
    logic [`XADC_DELAY_W-1:0] delay_cnt;
    logic                     delay_run;

    // Sample counter, reload wins over a trailing push
    always_ff @(posedge clk125)
    begin
        if (rst)
            remaining <= '0;
        else if (timer_start)
            remaining <= sample_count;
        else if (sample_tick && remaining != '0)
            remaining <= remaining - 1'b1;
    end

    assign last_sample = (remaining <= `XADC_COUNT_W'(1)); // Zero count acts as one

    //////////////////////////////////////////////////
    // Inter-sample delay
    //////////////////////////////////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            delay_run <= 1'b0;
            delay_cnt <= '0;
        end
        else if (delay_start)
        begin
            delay_run <= 1'b1;
            delay_cnt <= delay_cycles;
        end
        else if (delay_run)
        begin
            if (delay_cnt == '0)
                delay_run <= 1'b0;
            else
                delay_cnt <= delay_cnt - 1'b1;
        end
    end

    // High delay+1 cycles after delay_start
    assign delay_done = delay_run && (delay_cnt == '0);

endmodule

//--- source/sample_packer.sv
`timescale 1ns/1ps
`include "xadc_macros.svh"

module sample_packer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  xadc_data_pkg::sample_t      sample,
    input  logic                        sample_push,
    output logic                        pack_ready,
    output xadc_data_pkg::fifo_word_t   word,
    output logic                        word_last,
    input  logic                        word_taken
);
    localparam int SLOT_W = $clog2(`XADC_SLOTS);

    logic [SLOT_W-1:0]          slot;
    logic [`XADC_WORD_W-1:0]    acc;
    logic                       held;       // Word waiting for the writer
    logic                       held_last;
    logic                       closing;

    assign closing = sample_push && !held &&
                     ((slot == SLOT_W'(`XADC_SLOTS - 1)) || sample.last);

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            slot      <= '0;
            acc       <= '0;
            held      <= 1'b0;
            held_last <= 1'b0;
        end
        else if (held)
        begin
            if (word_taken)
            begin
                held <= 1'b0;
                acc  <= '0;     // Short words leave zero slots
            end
        end
        else if (sample_push)
        begin
            acc[`XADC_WORD_W-1]                       <= 1'b0;
            acc[`XADC_WORD_W-2 -: 3]                  <= sample.chan; // Header
            acc[slot * `XADC_RESULT_W +: `XADC_RESULT_W] <= sample.result;
            if (closing)
            begin
                slot      <= '0;
                held      <= 1'b1;
                held_last <= sample.last;
            end
            else
                slot <= slot + 1'b1;
        end
    end

    // Present the held word
    always_comb
    begin
        word       = '0;
        word.valid = held;
        word.data  = acc;
    end

    assign word_last  = held_last;
    assign pack_ready = !held;

endmodule

//--- source/frame_writer.sv
`timescale 1ns/1ps
`include "xadc_macros.svh"

module frame_writer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  xadc_data_pkg::fifo_word_t   word,
    input  logic                        word_last,
    output logic                        word_taken,
    output xadc_data_pkg::fifo_word_t   fifo_out,
    input  logic                        fifo_credit,
    output logic                        writer_idle
);
    import xadc_data_pkg::*;

    localparam int CREDIT_W = $clog2(`XADC_FIFO_CREDITS + 1);

    wr_state_e                  state;
    logic [CREDIT_W-1:0]        credits;
    logic [`XADC_LEN_W-1:0]     frame_cnt;  // Words already in this frame
    logic [`XADC_LEN_W-1:0]     next_len;
    logic                       end_frame;
    logic                       out_valid;
    logic                       out_eod;
    logic [`XADC_WORD_W-1:0]    out_data;
    logic [`XADC_LEN_W-1:0]     out_len;

    assign word_taken  = (state == WR_IDLE) && word.valid && (credits != '0);
    assign next_len    = frame_cnt + 1'b1;
    assign end_frame   = word_last || (next_len == `XADC_MAX_WORDS);
    assign writer_idle = (state == WR_IDLE);

    //////////////////////////////////////////////////
    // Credits and framing
    //////////////////////////////////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state     <= WR_IDLE;
            credits   <= CREDIT_W'(`XADC_FIFO_CREDITS);
            frame_cnt <= '0;
            out_valid <= 1'b0;
            out_eod   <= 1'b0;
        end
        else
        begin
            case ({word_taken, fifo_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // Spend and return cancel
            endcase

            case (state)
                WR_IDLE:
                begin
                    if (word_taken)
                    begin
                        out_valid <= 1'b1;
                        out_eod   <= end_frame;
                        frame_cnt <= end_frame ? '0 : next_len;
                        state     <= WR_EMIT;
                    end
                end
                WR_EMIT:
                begin
                    out_valid <= 1'b0;
                    out_eod   <= 1'b0;
                    state     <= WR_SETTLE;
                end
                WR_SETTLE: state <= WR_IDLE;
                default:   state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk125)
    begin
        if (word_taken)
        begin
            out_data <= word.data;
            out_len  <= next_len;
        end
    end

    always_comb
    begin
        fifo_out.valid       = out_valid;
        fifo_out.data        = out_data;
        fifo_out.packet_len  = out_len;
        fifo_out.end_of_data = out_eod;
    end

endmodule

//--- source/xadc_monitor.sv
`timescale 1ns/1ps
`include "xadc_macros.svh"

module xadc_monitor
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        cmd_rdy,
    input  xadc_ctrl_pkg::run_cmd_t     cmd,
    output logic                        conv_start,
    output logic [2:0]                  conv_chan,
    input  logic                        conv_done,
    input  logic [`XADC_RESULT_W-1:0]   conv_result,
    output xadc_data_pkg::fifo_word_t   fifo_out,
    input  logic                        fifo_credit,
    input  logic                        udp_done,
    output logic                        busy
);
    xadc_data_pkg::sample_t     sample;
    xadc_data_pkg::fifo_word_t  packed_word;
    logic                       sample_push;
    logic                       pack_ready;
    logic                       word_last;
    logic                       word_taken;
    logic                       timer_start;
    logic                       delay_start;
    logic                       last_sample;
    logic                       delay_done;
    logic                       writer_idle;

    //////////////////////////////////////////////////
    // Control path
    //////////////////////////////////////////////////

    sample_sequencer sample_sequencer_inst
    (
        .clk125      (clk125),
        .rst         (rst),
        .cmd_rdy     (cmd_rdy),
        .cmd         (cmd),
        .conv_start  (conv_start),
        .conv_chan   (conv_chan),
        .conv_done   (conv_done),
        .conv_result (conv_result),
        .pack_ready  (pack_ready),
        .sample      (sample),
        .sample_push (sample_push),
        .timer_start (timer_start),
        .delay_start (delay_start),
        .last_sample (last_sample),
        .delay_done  (delay_done),
        .writer_idle (writer_idle),
        .udp_done    (udp_done),
        .busy        (busy)
    );

    // Count and delay taken straight from the held command
    sample_timer sample_timer_inst
    (
        .clk125       (clk125),
        .rst          (rst),
        .timer_start  (timer_start),
        .sample_tick  (sample_push),
        .delay_start  (delay_start),
        .sample_count (cmd.sample_count),
        .delay_cycles (cmd.delay_cycles),
        .last_sample  (last_sample),
        .delay_done   (delay_done)
    );

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    sample_packer sample_packer_inst
    (
        .clk125      (clk125),
        .rst         (rst),
        .sample      (sample),
        .sample_push (sample_push),
        .pack_ready  (pack_ready),
        .word        (packed_word),
        .word_last   (word_last),
        .word_taken  (word_taken)
    );

    frame_writer frame_writer_inst
    (
        .clk125      (clk125),
        .rst         (rst),
        .word        (packed_word),
        .word_last   (word_last),
        .word_taken  (word_taken),
        .fifo_out    (fifo_out),
        .fifo_credit (fifo_credit),
        .writer_idle (writer_idle)
    );

endmodule

//--- bench/xadc_monitor_assert.sv
`timescale 1ns/1ps

module xadc_monitor_assert
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        conv_start,
    input  logic                        conv_done,
    input  logic                        busy,
    input  xadc_ctrl_pkg::seq_state_e   seq_state,
    input  logic                        out_valid,
    input  logic                        out_eod,
    input  logic                        credits_empty
);
    import xadc_ctrl_pkg::*;

    int failures = 0;   // Read by the testbench each cycle

    //////////////////////////////////////////////////
    // Conversion requests
    //////////////////////////////////////////////////

    conv_pulse: assert property (@(posedge clk125) disable iff (rst)
                                 conv_start |=> !conv_start)
        else
        begin
            $error("conv_start held for more than one cycle");
            failures++;
        end

    conv_in_run: assert property (@(posedge clk125) disable iff (rst)
                                  conv_start |-> busy)
        else
        begin
            $error("conv_start outside a run");
            failures++;
        end

    // Results only for a conversion in flight
    done_in_flight: assert property (@(posedge clk125) disable iff (rst)
                                     conv_done |-> seq_state == SEQ_WAIT_RESULT)
        else
        begin
            $error("conv_done without a conversion in flight");
            failures++;
        end

    // Word out of the writer
    word_credit: assert property (@(posedge clk125) disable iff (rst)
                                  out_valid |-> !$past(credits_empty))
        else
        begin
            $error("Word emitted with no credit left");
            failures++;
        end

    eod_valid: assert property (@(posedge clk125) disable iff (rst)
                                out_eod |-> out_valid)
        else
        begin
            $error("end_of_data without a valid word");
            failures++;
        end

endmodule

bind sample_sequencer xadc_monitor_assert seq_checks
(
    .clk125        (clk125),
    .rst           (rst),
    .conv_start    (conv_start),
    .conv_done     (conv_done),
    .busy          (busy),
    .seq_state     (state),
    .out_valid     (1'b0),
    .out_eod       (1'b0),
    .credits_empty (1'b0)
);

bind frame_writer xadc_monitor_assert wr_checks
(
    .clk125        (clk125),
    .rst           (rst),
    .conv_start    (1'b0),
    .conv_done     (1'b0),
    .busy          (1'b0),
    .seq_state     (xadc_ctrl_pkg::SEQ_IDLE),
    .out_valid     (out_valid),
    .out_eod       (out_eod),
    .credits_empty (credits == '0)
);

//--- bench/xadc_monitor_tb.sv
`timescale 1ns/1ps
`include "xadc_macros.svh"

module xadc_monitor_tb;
    import xadc_ctrl_pkg::*;
    import xadc_data_pkg::*;

    // Long channel run is about 760 x 12 cycles, the others a few hundred each
    localparam int TIMEOUT_CYCLES = 20000;

    logic                       clk125 = 1'b0;
    logic                       rst;
    logic                       cmd_rdy;
    run_cmd_t                   cmd;
    logic                       conv_start;
    logic [2:0]                 conv_chan;
    logic                       conv_done;
    logic [`XADC_RESULT_W-1:0]  conv_result;
    fifo_word_t                 fifo_out;
    logic                       fifo_credit;
    logic                       udp_done;
    logic                       busy;

    logic       hold_credits;   // FIFO keeps its credits
    logic       credit_pend;
    int         owed;           // Credits not yet returned
    int         cycles;
    int         conv_count;     // Conversions so far, also the ADC result
    integer     seed;
    logic [2:0] adc_wait;
    logic       adc_busy;

    fifo_word_t words[$];
    fifo_word_t expected[$];
    int         start_cycles[$];
    logic [2:0] start_chans[$];
    logic [2:0] expected_chans[$];
    int         first_word;
    int         first_start;
    int         frame_len;

    always #50 clk125 = ~clk125;

    xadc_monitor xadc_monitor_inst
    (
        .clk125      (clk125),
        .rst         (rst),
        .cmd_rdy     (cmd_rdy),
        .cmd         (cmd),
        .conv_start  (conv_start),
        .conv_chan   (conv_chan),
        .conv_done   (conv_done),
        .conv_result (conv_result),
        .fifo_out    (fifo_out),
        .fifo_credit (fifo_credit),
        .udp_done    (udp_done),
        .busy        (busy)
    );

    //////////////////////////////////////////////////
    // Error handling
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
        abort_run();
    endtask

    function automatic int protocol_failures();
        return xadc_monitor_inst.sample_sequencer_inst.seq_checks.failures +
               xadc_monitor_inst.frame_writer_inst.wr_checks.failures;
    endfunction

    //////////////////////////////////////////////////
    // ADC, FIFO and word monitor models
    //////////////////////////////////////////////////

    // Answers each conv_start after 1 to 4 cycles
    initial
    begin
        seed = 20;
        conv_done   <= 1'b0;
        conv_result <= '0;
        conv_count  <= 0;
        adc_busy    <= 1'b0;
        adc_wait    <= '0;
        forever
        begin
            @(posedge clk125);
            conv_done <= 1'b0;
            if (rst)
                adc_busy <= 1'b0;
            else if (conv_start)
            begin
                conv_count <= conv_count + 1;
                start_cycles.push_back(cycles);
                start_chans.push_back(conv_chan);
                adc_wait   <= 3'd1 + 3'($unsigned($random(seed)) % 4);
                adc_busy   <= 1'b1;
            end
            else if (adc_busy)
            begin
                if (adc_wait <= 3'd1)
                begin
                    conv_done   <= 1'b1;
                    conv_result <= 12'(conv_count);
                    adc_busy    <= 1'b0;
                end
                else
                    adc_wait <= adc_wait - 3'd1;
            end
        end
    end

    // One credit back two cycles after each word, owed credits queue up while held
    initial
    begin
        fifo_credit <= 1'b0;
        credit_pend <= 1'b0;
        owed        <= 0;
        forever
        begin
            @(posedge clk125);
            if (rst)
            begin
                fifo_credit <= 1'b0;
                credit_pend <= 1'b0;
                owed        <= 0;
            end
            else
            begin
                credit_pend <= fifo_out.valid;
                if (!hold_credits && (owed != 0 || credit_pend))
                begin
                    fifo_credit <= 1'b1;
                    owed        <= owed + int'(credit_pend) - 1;
                end
                else
                begin
                    fifo_credit <= 1'b0;
                    owed        <= owed + int'(credit_pend);
                end
            end
        end
    end

    initial
    begin
        cycles <= 0;
        forever
        begin
            @(posedge clk125);
            cycles <= cycles + 1;
            if (!rst && fifo_out.valid)
                words.push_back(fifo_out);
            if (cycles >= TIMEOUT_CYCLES)
            begin
                $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
                abort_run();
            end
            else if (protocol_failures() != 0)
            begin
                $display("Protocol assertion failed at time %0t", $time);
                abort_run();
            end
        end
    end

    //////////////////////////////////////////////////
    // Expected words and run control
    //////////////////////////////////////////////////

    // Five results per word, slot 0 first, frame closes on channel end or size limit
    task automatic add_expected(input int chan, input int count, input int base);
        fifo_word_t w;
        int         n;
        int         k;
        for (k = 0; k < count; k++)
            expected_chans.push_back(3'(chan));
        n = 0;
        while (n < count)
        begin
            w       = '0;
            w.valid = 1'b1;
            w.data[`XADC_WORD_W-2 -: 3] = chan[2:0];
            for (k = 0; k < `XADC_SLOTS && n < count; k++)
            begin
                w.data[k*`XADC_RESULT_W +: `XADC_RESULT_W] = 12'(base + n + 1);
                n++;
            end
            frame_len++;
            w.packet_len  = 12'(frame_len);
            w.end_of_data = (n == count) || (frame_len == `XADC_MAX_WORDS);
            if (w.end_of_data)
                frame_len = 0;
            expected.push_back(w);
        end
    endtask

    task automatic start_run(input logic [3:0] chip, input int count, input int delay);
        int c;
        expected.delete();
        expected_chans.delete();
        frame_len   = 0;
        first_word  = words.size();
        first_start = start_cycles.size();
        if (chip >= 4'(`XADC_CHANNELS))
        begin
            for (c = 0; c < `XADC_CHANNELS; c++)
                add_expected(c, count, conv_count + c * count);
        end
        else
            add_expected(int'(chip), count, conv_count);
        @(posedge clk125);
        cmd     <= '{chip_id: chip, sample_count: `XADC_COUNT_W'(count),
                     delay_cycles: `XADC_DELAY_W'(delay)};
        cmd_rdy <= 1'b1;
        while (!busy)
            @(negedge clk125);
    endtask

    task automatic check_words();
        fifo_word_t got;
        fifo_word_t want;
        int         i;
        while (words.size() < first_word + expected.size())
            @(negedge clk125);
        for (i = 0; i < expected.size(); i++)
        begin
            got  = words[first_word + i];
            want = expected[i];
            assert (got.data == want.data)
                else report_mismatch($sformatf("fifo_out.data[%0d]", i), got.data, want.data);
            assert (got.packet_len == want.packet_len)
                else report_mismatch($sformatf("fifo_out.packet_len[%0d]", i),
                                     64'(got.packet_len), 64'(want.packet_len));
            assert (got.end_of_data == want.end_of_data)
                else report_mismatch($sformatf("fifo_out.end_of_data[%0d]", i),
                                     64'(got.end_of_data), 64'(want.end_of_data));
        end

        // Conversion requests, one per sample in channel order
        assert (start_chans.size() == first_start + expected_chans.size())
            else report_mismatch("conv_start count", 64'(start_chans.size() - first_start),
                                 64'(expected_chans.size()));
        for (i = 0; i < expected_chans.size(); i++)
        begin
            assert (start_chans[first_start + i] == expected_chans[i])
                else report_mismatch($sformatf("conv_chan[%0d]", i),
                                     64'(start_chans[first_start + i]),
                                     64'(expected_chans[i]));
        end
    endtask

    // busy must wait for cmd_rdy low and udp_done high
    task automatic end_run();
        int i;
        @(posedge clk125);
        udp_done <= 1'b1;   // cmd_rdy still high
        for (i = 0; i < 6; i++)
        begin
            @(negedge clk125);
            assert (busy) else report_mismatch("busy", 64'(busy), 64'd1);
        end
        @(posedge clk125);
        udp_done <= 1'b0;
        cmd_rdy  <= 1'b0;
        for (i = 0; i < 4; i++)
        begin
            @(negedge clk125);
            assert (busy) else report_mismatch("busy", 64'(busy), 64'd1);
        end
        @(posedge clk125);
        udp_done <= 1'b1;
        while (busy)
            @(negedge clk125);
        @(posedge clk125);
        udp_done <= 1'b0;
        while (owed != 0 || credit_pend || fifo_credit)
            @(negedge clk125);
        assert (words.size() == first_word + expected.size())
            else report_mismatch("fifo_out word count", 64'(words.size() - first_word),
                                 64'(expected.size()));
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_single_channel();
        start_run(4'd3, 7, 2);
        check_words();
        end_run();
    endtask

    task automatic test_all_channels();
        start_run(4'd8, 3, 1);   // One short word per chip
        check_words();
        end_run();
    endtask

    task automatic test_sample_delay();
        int i;
        int gap;
        start_run(4'd6, 4, 20);
        check_words();
        for (i = first_start + 1; i < start_cycles.size(); i++)
        begin
            gap = start_cycles[i] - start_cycles[i-1];
            assert (gap >= 21) else report_mismatch("conv_start spacing", 64'(gap), 64'd21);
        end
        end_run();
    endtask

    task automatic test_credit_stall();
        int i;
        @(posedge clk125);
        hold_credits <= 1'b1;
        start_run(4'd5, 30, 0);
        while (words.size() < first_word + 4)
            @(negedge clk125);
        for (i = 0; i < 40; i++)
        begin
            @(negedge clk125);
            assert (words.size() == first_word + 4)
                else report_mismatch("fifo_out word count", 64'(words.size() - first_word),
                                     64'd4);
        end
        @(posedge clk125);
        hold_credits <= 1'b0;
        check_words();
        end_run();
    endtask

    task automatic test_long_channel();
        start_run(4'd2, 760, 0);     // Crosses the frame size limit
        check_words();
        end_run();
    endtask

    initial
    begin
        rst          <= 1'b1;
        cmd_rdy      <= 1'b0;
        cmd          <= '0;
        udp_done     <= 1'b0;
        hold_credits <= 1'b0;
        repeat (3) @(posedge clk125);
        rst <= 1'b0;

        test_single_channel();
        test_all_channels();
        test_sample_delay();
        test_credit_stall();
        test_long_channel();

        if (protocol_failures() == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("Protocol assertion failed before the end of the run");
            abort_run();
        end
    end

endmodule

//--- vlog.f
+incdir+source
source/xadc_ctrl_pkg.sv
source/xadc_data_pkg.sv
source/sample_sequencer.sv
source/sample_timer.sv
source/sample_packer.sv
source/frame_writer.sv
source/xadc_monitor.sv
bench/xadc_monitor_assert.sv
bench/xadc_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the XADC monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module xadc_monitor_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep going after an assertion error so the testbench reports it
./obj_dir/Vxadc_monitor_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
